/* axis_credit_buf.f */
verilog/axis_buf_pkg.sv
verilog/buf_ctrl.sv
verilog/beat_store.sv
verilog/credit_tx_stage.sv
verilog/axis_credit_buf.sv
tb/axis_credit_buf_sva.sv
tb/axis_credit_buf_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert -Wno-fatal \
	-f axis_credit_buf.f \
	--top-module axis_credit_buf_tb \
	-Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

OUTPUT=$("./$BUILD_DIR/sim")
STATUS=$?
echo "$OUTPUT"

if [ $STATUS -ne 0 ]; then
	echo "Simulation exited with status $STATUS"
	exit 1
fi

# Pass only if the testbench printed its pass line
if echo "$OUTPUT" | grep -qx "test passed"; then
	exit 0
fi
exit 1

/* tb/axis_credit_buf_sva.sv */
`timescale 1ns/1ps

module axis_credit_buf_sva (
	input logic                  axi_tx,
	input logic                  rst_n,
	input logic                  in_ready,
	input logic                  wr_en,
	input logic                  pop,
	input logic                  credit_ret,
	input axis_buf_pkg::occ_t    occ_q,
	input axis_buf_pkg::credit_t credit_q
);

	import axis_buf_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Shadow credit count

	// Credits held, counted from sends and returns
	int held;

	always_ff @(posedge axi_tx) begin
		if (!rst_n)
			held <= CREDIT_INIT;
		else
			held <= held - int'(pop) + int'(credit_ret);
	end

	//////////////////////////////////////////////////////////////////////
	// Handshake

	// Ready drops only on a push that fills the last slot
	property ready_falls_on_fill;
		@(posedge axi_tx) disable iff (!rst_n)
		$fell(in_ready) |-> $past(wr_en && !pop);
	endproperty

	// Ready returns only on a pop that frees a slot
	property ready_rises_on_drain;
		@(posedge axi_tx) disable iff (!rst_n)
		$rose(in_ready) |-> $past(pop && !wr_en);
	endproperty

	//////////////////////////////////////////////////////////////////////
	// Credits and occupancy

	// No send without a credit
	property pop_needs_credit;
		@(posedge axi_tx) disable iff (!rst_n)
		pop |-> (held > 0);
	endproperty

	// Sink never grants beyond its capacity
	property credit_bounded;
		@(posedge axi_tx) disable iff (!rst_n)
		credit_q <= credit_t'(CREDIT_INIT);
	endproperty

	property occ_bounded;
		@(posedge axi_tx) disable iff (!rst_n)
		occ_q <= occ_t'(FIFO_DEPTH);
	endproperty

	a_ready_fall: assert property (ready_falls_on_fill)
		else $error("in_ready fell without a filling push");
	a_ready_rise: assert property (ready_rises_on_drain)
		else $error("in_ready rose without a freeing pop");
	a_pop: assert property (pop_needs_credit)
		else $error("pop issued with zero credits");
	a_credit: assert property (credit_bounded)
		else $error("credit count above initial grant");
	a_occ: assert property (occ_bounded)
		else $error("occupancy above buffer depth");

endmodule

bind buf_ctrl axis_credit_buf_sva sva0 (
	.axi_tx     (axi_tx),
	.rst_n      (rst_n),
	.in_ready   (in_ready),
	.wr_en      (wr_en),
	.pop        (pop),
	.credit_ret (credit_ret),
	.occ_q      (occ_q),
	.credit_q   (credit_q)
);

/* tb/axis_credit_buf_tb.sv */
`timescale 1ns/1ps

module axis_credit_buf_tb;

	import axis_buf_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Run length

	localparam logic [31:0] SEED = 32'hf4f6ee29;
	localparam int TOTAL_BEATS  = 600;
	// Sparse traffic first so the buffer is mostly empty
	localparam int SPARSE_BEATS = 60;
	// Credits withheld once this many beats are out
	localparam int HOLD_START   = 300;
	localparam int MAX_CYCLES   = 4 * TOTAL_BEATS + 2000;

	//////////////////////////////////////////////////////////////////////
	// DUT signals

	logic       axi_tx;
	logic       rst_n;
	logic       in_valid;
	axis_beat_t in_beat;
	logic       in_ready;
	logic       credit_ret;
	logic       out_valid;
	axis_beat_t out_beat;
	pkt_cnt_t   pkt_count;

	axis_credit_buf dut0 (
		.axi_tx     (axi_tx),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_beat    (in_beat),
		.in_ready   (in_ready),
		.credit_ret (credit_ret),
		.out_valid  (out_valid),
		.out_beat   (out_beat),
		.pkt_count  (pkt_count)
	);

	//////////////////////////////////////////////////////////////////////
	// Model state

	// Accepted beats not yet seen at the output
	axis_beat_t  exp_q[$];
	// Cycle in which each owed credit goes back
	int          ret_due[$];
	int          exp_credit;
	pkt_cnt_t    exp_pkt;
	int          checked;
	int          cycles;
	int          lat_due;
	int          lat_checks;
	int          full_cycles;
	logic        hold_credits;
	logic        hold_used;
	logic        bp_seen;
	logic        running;
	logic        done;

	//////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
			$display("test failed");
			$fatal(1, "Beat mismatch on %s", name);
		end
	endtask

	task automatic check_count(input string name, input pkt_cnt_t exp, input pkt_cnt_t act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
			$display("test failed");
			$fatal(1, "Count mismatch on %s", name);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
			$display("test failed");
			$fatal(1, "Bit mismatch on %s", name);
		end
	endtask

	// Protocol failure with no single wrong value
	task automatic abort_run(input string why);
		$display("t=%0t %s", $time, why);
		$display("test failed");
		$fatal(1, "%s", why);
	endtask

	// Random beat with tlast about one in four
	function automatic axis_beat_t make_beat();
		axis_beat_t b;
		b.tdata = $urandom;
		b.tuser = USER_WIDTH'($urandom);
		b.tid   = ID_WIDTH'($urandom);
		b.tdest = DEST_WIDTH'($urandom);
		b.tkeep = KEEP_WIDTH'($urandom);
		b.tlast = ($urandom_range(0, 3) == 0);
		return b;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Clock and cycle counter

	initial begin
		axi_tx = 1'b0;
		forever #4 axi_tx = ~axi_tx;
	end

	always @(posedge axi_tx)
		cycles <= cycles + 1;

	//////////////////////////////////////////////////////////////////////
	// Monitor, model, sink and source

	// Samples the cycle that just ended, then drives the next one
	always @(posedge axi_tx) begin
		axis_beat_t head;
		int         occ_dut;
		int         idx;
		logic       give_ret;
		logic       offer;
		if (running && !done) begin
			// DUT occupancy excludes the beat already in the output register
			occ_dut = exp_q.size() - int'(out_valid);
			check_bit("in_ready", occ_dut < FIFO_DEPTH, in_ready);
			check_count("pkt_count", exp_pkt, pkt_count);

			// Empty buffer path takes two cycles from acceptance
			if (lat_due == cycles + 1)
				check_bit("out_valid one cycle after acceptance", 1'b0, out_valid);
			if (lat_due == cycles) begin
				check_bit("out_valid two cycles after acceptance", 1'b1, out_valid);
				lat_checks++;
				lat_due = -1;
			end

			if (out_valid) begin
				if (exp_credit == 0) begin
					abort_run("out_valid was high while no credit was held");
				end else if (exp_q.size() == 0) begin
					abort_run("out_valid was high with no accepted beat outstanding");
				end else begin
					head = exp_q.pop_front();
					check_beat("out_beat", head, out_beat);
					if (head.tlast)
						exp_pkt = exp_pkt + pkt_cnt_t'(1);
					exp_credit--;
					checked++;
					// Sink frees its slot 0 to 5 cycles later
					ret_due.push_back(cycles + 1 + int'($urandom_range(0, 5)));
					if (checked == TOTAL_BEATS)
						done <= 1'b1;
				end
			end else begin
				check_bit("out_beat.tlast while idle", 1'b0, out_beat.tlast);
			end
			if (credit_ret)
				exp_credit++;

			if (in_valid && in_ready) begin
				if (occ_dut == 0 && exp_credit > 0)
					lat_due = cycles + 2;
				exp_q.push_back(in_beat);
			end

			// Back-pressure phase
			if (hold_credits) begin
				if (!in_ready)
					full_cycles++;
				if (full_cycles >= 8) begin
					hold_credits = 1'b0;
					bp_seen = 1'b1;
				end
			end else if (!hold_used && checked >= HOLD_START) begin
				hold_credits = 1'b1;
				hold_used = 1'b1;
			end

			// Sink returns at most one credit per cycle
			give_ret = 1'b0;
			if (!hold_credits) begin
				for (idx = 0; idx < ret_due.size(); idx++) begin
					if (!give_ret && ret_due[idx] <= cycles + 1) begin
						ret_due.delete(idx);
						give_ret = 1'b1;
					end
				end
			end
			credit_ret <= give_ret;

			// Source keeps a stalled beat steady
			if (!(in_valid && !in_ready)) begin
				if (hold_credits)
					offer = 1'b1;
				else if (checked < SPARSE_BEATS)
					offer = ($urandom_range(0, 5) == 0);
				else
					offer = ($urandom_range(0, 3) != 0);
				in_valid <= offer;
				if (offer)
					in_beat <= make_beat();
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_beat = '0;
		credit_ret = 1'b0;
		exp_credit = CREDIT_INIT;
		exp_pkt = '0;
		checked = 0;
		cycles = 0;
		lat_due = -1;
		lat_checks = 0;
		full_cycles = 0;
		hold_credits = 1'b0;
		hold_used = 1'b0;
		bp_seen = 1'b0;
		running = 1'b0;
		done = 1'b0;

		// Two edges in reset
		repeat (2) @(posedge axi_tx);
		check_bit("out_valid after reset", 1'b0, out_valid);
		check_bit("in_ready after reset", 1'b1, in_ready);
		check_count("pkt_count after reset", pkt_cnt_t'(0), pkt_count);
		rst_n <= 1'b1;
		running <= 1'b1;

		while (!done && cycles < MAX_CYCLES)
			@(posedge axi_tx);

		if (!done)
			$display("Timeout after %0d cycles, %0d of %0d beats checked",
				cycles, checked, TOTAL_BEATS);
		else if (lat_checks == 0)
			$display("No beat ever passed through an empty buffer");
		else if (!bp_seen)
			$display("Buffer never filled while credits were withheld");

		if (done && lat_checks > 0 && bp_seen) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "Run ended in failure");
		end
	end

endmodule

/* verilog/axis_buf_pkg.sv */
package axis_buf_pkg;

	//////////////////////////////////////////////////////////////////////
	// Stream widths

	// Payload word
	localparam int DATA_WIDTH = 32;

	// Sideband fields
	localparam int USER_WIDTH = 4;
	localparam int ID_WIDTH   = 4;
	localparam int DEST_WIDTH = 4;

	// One keep bit per data byte
	localparam int KEEP_WIDTH = DATA_WIDTH / 8;

	//////////////////////////////////////////////////////////////////////
	// Buffer geometry

	// Stored beats, power of two
	localparam int FIFO_DEPTH = 16;
	localparam int ADDR_BITS  = $clog2(FIFO_DEPTH);

	//////////////////////////////////////////////////////////////////////
	// Credit and packet accounting

	// Sink receive capacity, granted at reset
	localparam int CREDIT_INIT = 4;

	// Must hold the full grant, not just CREDIT_INIT-1
	localparam int CREDIT_BITS = $clog2(CREDIT_INIT + 1);

	// Sent packet counter, wraps
	localparam int PKT_CNT_BITS = 16;

	//////////////////////////////////////////////////////////////////////
	// Types

	// One stream beat, 49 bits
	typedef struct packed {
		logic [DATA_WIDTH-1:0] tdata;
		logic [USER_WIDTH-1:0] tuser;
		logic [ID_WIDTH-1:0]   tid;
		logic [DEST_WIDTH-1:0] tdest;
		logic [KEEP_WIDTH-1:0] tkeep;
		logic                  tlast;
	} axis_beat_t;

	// Occupancy, one extra bit so full is representable
	typedef logic [ADDR_BITS:0] occ_t;

	// Credits currently held
	typedef logic [CREDIT_BITS-1:0] credit_t;

	// Completed packets sent
	typedef logic [PKT_CNT_BITS-1:0] pkt_cnt_t;

endpackage

/* verilog/axis_credit_buf.sv */
`timescale 1ns/1ps

module axis_credit_buf (
	input  logic                     axi_tx,
	input  logic                     rst_n,

	// Input stream, valid/ready
	input  logic                     in_valid,
	input  axis_buf_pkg::axis_beat_t in_beat,
	output logic                     in_ready,

	// Credit return from sink
	input  logic                     credit_ret,

	// Output stream, credit based
	output logic                     out_valid,
	output axis_buf_pkg::axis_beat_t out_beat,

	// Sent packet count
	output axis_buf_pkg::pkt_cnt_t   pkt_count
);

	import axis_buf_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Internal wires

	// Write side
	logic                 wr_en;
	logic [ADDR_BITS-1:0] wr_addr;

	// Read side
	logic [ADDR_BITS-1:0] rd_addr;
	axis_beat_t           rd_beat;
	logic                 pop;

	//////////////////////////////////////////////////////////////////////
	// Control

	// Pointers, occupancy, credits
	buf_ctrl ctrl0 (
		.axi_tx     (axi_tx),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.credit_ret (credit_ret),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.rd_addr    (rd_addr),
		.pop        (pop)
	);

	//////////////////////////////////////////////////////////////////////
	// Datapath

	// Beat memory, written straight from the input port
	beat_store #(
		.payload_t (axis_beat_t)
	) store0 (
		.axi_tx  (axi_tx),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (in_beat),
		.rd_addr (rd_addr),
		.rd_beat (rd_beat)
	);

	// Output register and packet count
	credit_tx_stage tx0 (
		.axi_tx    (axi_tx),
		.rst_n     (rst_n),
		.pop       (pop),
		.rd_beat   (rd_beat),
		.out_valid (out_valid),
		.out_beat  (out_beat),
		.pkt_count (pkt_count)
	);

endmodule

/* verilog/beat_store.sv */
`timescale 1ns/1ps

module beat_store #(
	parameter type payload_t = axis_buf_pkg::axis_beat_t
) (
	input  logic                               axi_tx,

	// Write port, clocked
	input  logic                               wr_en,
	input  logic [axis_buf_pkg::ADDR_BITS-1:0] wr_addr,
	input  payload_t                           wr_data,

	// Read port, combinational
	input  logic [axis_buf_pkg::ADDR_BITS-1:0] rd_addr,
	output payload_t                           rd_beat
);

	import axis_buf_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Storage array

	// One entry per buffered beat
	payload_t mem [FIFO_DEPTH];

	//////////////////////////////////////////////////////////////////////
	// Write

	// Entry valid from the accepting edge on
	always_ff @(posedge axi_tx) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	//////////////////////////////////////////////////////////////////////
	// Read

	// Head beat visible in the same cycle as the pop decision
	assign rd_beat = mem[rd_addr];

endmodule

/* verilog/buf_ctrl.sv */
`timescale 1ns/1ps

module buf_ctrl (
	input  logic                              axi_tx,
	input  logic                              rst_n,

	// Upstream handshake
	input  logic                              in_valid,
	output logic                              in_ready,

	// Sink returns one credit per pulse
	input  logic                              credit_ret,

	// Memory write side
	output logic                              wr_en,
	output logic [axis_buf_pkg::ADDR_BITS-1:0] wr_addr,

	// Memory read side and send request
	output logic [axis_buf_pkg::ADDR_BITS-1:0] rd_addr,
	output logic                              pop
);

	import axis_buf_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// State

	logic [ADDR_BITS-1:0] wr_ptr_q;
	logic [ADDR_BITS-1:0] rd_ptr_q;
	occ_t                 occ_q;
	credit_t              credit_q;

	//////////////////////////////////////////////////////////////////////
	// Handshake and pop decision

	// Room for one more beat
	assign in_ready = (occ_q < occ_t'(FIFO_DEPTH));

	// Beat moves only on a completed handshake
	assign wr_en = in_valid && in_ready;

	// Send when data is held and the sink has room
	assign pop = (occ_q != '0) && (credit_q != '0);

	assign wr_addr = wr_ptr_q;
	assign rd_addr = rd_ptr_q;

	//////////////////////////////////////////////////////////////////////
	// Pointers

	always_ff @(posedge axi_tx) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			// Advance write slot, wrap at last entry
			if (wr_en) begin
				if (wr_ptr_q == ADDR_BITS'(FIFO_DEPTH - 1))
					wr_ptr_q <= '0;
				else
					wr_ptr_q <= wr_ptr_q + 1'b1;
			end

			// Head moves past the beat just sent
			if (pop) begin
				if (rd_ptr_q == ADDR_BITS'(FIFO_DEPTH - 1))
					rd_ptr_q <= '0;
				else
					rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Occupancy

	always_ff @(posedge axi_tx) begin
		if (!rst_n) begin
			occ_q <= '0;
		end else begin
			case ({wr_en, pop})
				// Push only
				2'b10:   occ_q <= occ_q + 1'b1;
				// Pop only
				2'b01:   occ_q <= occ_q - 1'b1;
				// Idle, or push and pop cancel
				default: occ_q <= occ_q;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Credits

	always_ff @(posedge axi_tx) begin
		if (!rst_n) begin
			// Sink starts empty, full grant available
			credit_q <= credit_t'(CREDIT_INIT);
		end else begin
			case ({pop, credit_ret})
				// Beat sent, one credit spent
				2'b10:   credit_q <= credit_q - 1'b1;
				// Sink freed a slot
				2'b01:   credit_q <= credit_q + 1'b1;
				// Nothing, or spend and return together
				default: credit_q <= credit_q;
			endcase
		end
	end

endmodule

/* verilog/credit_tx_stage.sv */
`timescale 1ns/1ps

module credit_tx_stage (
	input  logic                    axi_tx,
	input  logic                    rst_n,

	// Send request from control
	input  logic                    pop,

	// Head beat from memory
	input  axis_buf_pkg::axis_beat_t rd_beat,

	// Downstream, no ready
	output logic                    out_valid,
	output axis_buf_pkg::axis_beat_t out_beat,

	// Completed packets sent
	output axis_buf_pkg::pkt_cnt_t   pkt_count
);

	import axis_buf_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Output register

	axis_beat_t beat_q;
	logic       valid_q;
	pkt_cnt_t   pkt_q;

	// Capture head beat at the pop edge
	always_ff @(posedge axi_tx) begin
		if (pop)
			beat_q <= rd_beat;
	end

	// Valid for exactly the cycle after each pop
	always_ff @(posedge axi_tx) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= pop;
	end

	assign out_valid = valid_q;

	// tlast only meaningful alongside valid
	always_comb begin
		out_beat       = beat_q;
		out_beat.tlast = beat_q.tlast && valid_q;
	end

	//////////////////////////////////////////////////////////////////////
	// Packet counter

	// Counts at the end of a valid cycle with tlast, wraps
	always_ff @(posedge axi_tx) begin
		if (!rst_n)
			pkt_q <= '0;
		else if (valid_q && beat_q.tlast)
			pkt_q <= pkt_q + 1'b1;
	end

	assign pkt_count = pkt_q;

endmodule
